/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Test passed
FAIL_MSG  ?= Test failed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
source/progmem_pkg.sv
source/word_bram.sv
source/program_memory.sv
source/axil_mem_slave.sv
source/mem_subsystem_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_subsystem.sv

/* source/axil_mem_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_mem_slave
    import progmem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  axil_req_t         axil_req,
    output axil_rsp_t         axil_rsp,
    output mem_req_t          mem_req,
    input  logic [DATA_W-1:0] data_rdata    // one cycle after ren
);

    slave_state_e state;

    logic wr_take;                           // aw and w transfer this cycle
    logic rd_take;                           // ar transfers this cycle
    logic wr_err;
    logic rd_err;

    // response registers
    logic              bvalid_q;
    logic              rvalid_q;
    axil_resp_e        bresp_q;
    axil_resp_e        rresp_q;
    logic [DATA_W-1:0] rdata_q;

    // write wins when both are pending in idle
    assign wr_take = (state == IDLE) && axil_req.awvalid && axil_req.wvalid;
    assign rd_take = (state == IDLE) && axil_req.arvalid && !wr_take;

    // range check on the full byte address
    assign wr_err = axil_req.awaddr >= AXI_ADDR_W'(MEM_BYTES);
    assign rd_err = axil_req.araddr >= AXI_ADDR_W'(MEM_BYTES);

    // single-cycle memory request, issued on the acceptance cycle
    always_comb begin
        if (wr_take) begin
            mem_req.word_addr = axil_req.awaddr[MEM_WORD_ADDR_W+1:2];
        end else begin
            mem_req.word_addr = axil_req.araddr[MEM_WORD_ADDR_W+1:2];
        end
        mem_req.wdata   = axil_req.wdata;
        mem_req.byte_en = axil_req.wstrb;
        mem_req.wen     = wr_take && !wr_err;    // out of range writes dropped
        mem_req.ren     = rd_take && !rd_err;
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_take) begin
                        bvalid_q <= 1'b1;        // bram written on this edge
                        state    <= WRITE_RESP;
                    end else if (rd_take) begin
                        state <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    rvalid_q <= 1'b1;            // rdata_q loads on same edge
                    state    <= READ_RESP;
                end
                READ_RESP: begin
                    if (axil_req.rready) begin
                        rvalid_q <= 1'b0;
                        state    <= IDLE;
                    end
                end
                WRITE_RESP: begin
                    if (axil_req.bready) begin
                        bvalid_q <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload, held until the response transfers
    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp_q <= wr_err ? SLVERR : OKAY;
        end
        if (rd_take) begin
            rresp_q <= rd_err ? SLVERR : OKAY;
        end
        if (state == READ_WAIT) begin
            rdata_q <= (rresp_q == SLVERR) ? '0 : data_rdata;  // zero on error
        end
    end

    // readies are low outside idle, so nothing new during a held response
    always_comb begin
        axil_rsp.awready = wr_take;
        axil_rsp.wready  = wr_take;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = rd_take;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid_q;
    end

endmodule

`default_nettype wire

/* source/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import progmem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  axil_req_t         axil_req,     // from the axi4-lite master
    output axil_rsp_t         axil_rsp,
    input  logic [31:0]       pc,           // byte program counter
    output logic [DATA_W-1:0] instr         // word at pc, one cycle later
);

    mem_req_t          mem_req;             // slave to memory
    logic [DATA_W-1:0] data_rdata;          // memory to slave

    // data port, axi4-lite to single-cycle requests
    axil_mem_slave u_slave (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .mem_req    (mem_req),
        .data_rdata (data_rdata)
    );

    // upper pc bits dropped, so fetch wraps at 32 KiB
    program_memory u_mem (
        .clk        (clk),
        .pc_word    (pc[MEM_WORD_ADDR_W+1:2]),
        .mem_req    (mem_req),
        .instr      (instr),
        .data_rdata (data_rdata)
    );

endmodule

`default_nettype wire

/* source/progmem_pkg.sv */
`default_nettype none

package progmem_pkg;

    // memory geometry
    localparam int WORDS_PER_BANK  = 2048;                 // words per bank
    localparam int NUM_BANKS       = 4;
    localparam int BANK_IDX_W      = 11;                   // in-bank word index
    localparam int BANK_SEL_W      = 2;                    // bank number
    localparam int MEM_WORD_ADDR_W = 13;                   // word address, whole memory
    localparam int MEM_BYTES       = NUM_BANKS * WORDS_PER_BANK * 4;  // 32 KiB

    // bus widths
    localparam int DATA_W     = 32;
    localparam int STRB_W     = 4;                         // one strobe per byte
    localparam int AXI_ADDR_W = 32;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2                                      // out-of-range access
    } axil_resp_e;

    typedef enum logic [1:0] {
        IDLE,                                              // ready to accept
        READ_WAIT,                                         // bram data in flight
        READ_RESP,                                         // rvalid held
        WRITE_RESP                                         // bvalid held
    } slave_state_e;

    // single-cycle data port request
    typedef struct packed {
        logic [MEM_WORD_ADDR_W-1:0] word_addr;
        logic [DATA_W-1:0]          wdata;
        logic [STRB_W-1:0]          byte_en;
        logic                       wen;
        logic                       ren;
    } mem_req_t;

    // master-driven axi4-lite signals
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  awvalid;
        logic [DATA_W-1:0]     wdata;
        logic [STRB_W-1:0]     wstrb;
        logic                  wvalid;
        logic                  bready;
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axil_req_t;

    // slave-driven axi4-lite signals
    typedef struct packed {
        logic              awready;
        logic              wready;
        axil_resp_e        bresp;
        logic              bvalid;
        logic              arready;
        logic [DATA_W-1:0] rdata;
        axil_resp_e        rresp;
        logic              rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* source/program_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module program_memory
    import progmem_pkg::*;
(
    input  logic                       clk,
    input  logic [MEM_WORD_ADDR_W-1:0] pc_word,     // fetch word address, already wrapped
    input  mem_req_t                   mem_req,
    output logic [DATA_W-1:0]          instr,
    output logic [DATA_W-1:0]          data_rdata
);

    // address split, bank from the top bits
    logic [BANK_SEL_W-1:0] pc_bank;
    logic [BANK_IDX_W-1:0] pc_idx;
    logic [BANK_SEL_W-1:0] data_bank;
    logic [BANK_IDX_W-1:0] data_idx;

    // registered bank numbers, aligned with bram output regs
    logic [BANK_SEL_W-1:0] pc_bank_q;
    logic [BANK_SEL_W-1:0] data_bank_q;

    logic [DATA_W-1:0] bank_instr [NUM_BANKS];
    logic [DATA_W-1:0] bank_rdata [NUM_BANKS];

    assign pc_bank   = pc_word[MEM_WORD_ADDR_W-1:BANK_IDX_W];
    assign pc_idx    = pc_word[BANK_IDX_W-1:0];
    assign data_bank = mem_req.word_addr[MEM_WORD_ADDR_W-1:BANK_IDX_W];
    assign data_idx  = mem_req.word_addr[BANK_IDX_W-1:0];

    always_ff @(posedge clk) begin
        pc_bank_q <= pc_bank;                  // fetch every cycle
        if (mem_req.ren) begin
            data_bank_q <= data_bank;          // follows the bram read register
        end
    end

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        logic bank_wen;

        // write steering, only the addressed bank sees wen
        assign bank_wen = mem_req.wen && (data_bank == BANK_SEL_W'(g));

        word_bram u_bram (
            .clk       (clk),
            .instr_idx (pc_idx),
            .data_idx  (data_idx),
            .wen       (bank_wen),
            .byte_en   (mem_req.byte_en),
            .wdata     (mem_req.wdata),
            .ren       (mem_req.ren),          // all banks read, mux picks one
            .instr     (bank_instr[g]),
            .rdata     (bank_rdata[g])
        );
    end

    // output muxes off the delayed bank numbers
    assign instr      = bank_instr[pc_bank_q];
    assign data_rdata = bank_rdata[data_bank_q];

endmodule

`default_nettype wire

/* source/word_bram.sv */
`timescale 1ns/1ps
`default_nettype none

module word_bram
    import progmem_pkg::*;
(
    input  logic                  clk,
    input  logic [BANK_IDX_W-1:0] instr_idx,   // fetch index within bank
    input  logic [BANK_IDX_W-1:0] data_idx,    // load/store index within bank
    input  logic                  wen,         // already gated to this bank
    input  logic [STRB_W-1:0]     byte_en,
    input  logic [DATA_W-1:0]     wdata,
    input  logic                  ren,
    output logic [DATA_W-1:0]     instr,       // registered, one cycle
    output logic [DATA_W-1:0]     rdata        // registered on ren
);

    logic [DATA_W-1:0] mem [WORDS_PER_BANK];   // inferred dual-port ram

    // fetch port, read only, reads every cycle
    always_ff @(posedge clk) begin
        instr <= mem[instr_idx];               // old data on a colliding write
    end

    // data port, byte-wise write
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (byte_en[b]) begin
                    mem[data_idx][8*b +: 8] <= wdata[8*b +: 8];  // enabled lanes only
                end
            end
        end
    end

    // data port read register
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[data_idx];            // holds last read otherwise
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 4;    // 8 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;                   // released on a falling edge
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
    import progmem_pkg::*;
();

    localparam int TIMEOUT  = 50;           // cycles allowed per wait
    localparam int MAX_ROWS = 64;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_FETCH} op_e;
    typedef enum logic [1:0] {SIG_AW, SIG_AR, SIG_B, SIG_R} rsp_sig_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;                  // byte address or pc
        logic [31:0] data;
        logic [3:0]  strb;
        logic [3:0]  delay;                 // cycles of bready/rready held low
        logic [31:0] exp_data;
        axil_resp_e  exp_resp;
    } row_t;

    logic        clk;
    logic        reset;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] pc;
    logic [31:0] instr;

    row_t        rows [MAX_ROWS];
    int          n_rows;
    logic [31:0] written_q [$];             // fully written byte addresses
    logic [31:0] model_mem [MEM_BYTES/4];   // reference memory
    int          errors;
    int          checks;

    tb_clock_gen clk_gen (.clk(clk), .reset(reset));

    mem_subsystem_top dut0 (
        .clk      (clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .pc       (pc),
        .instr    (instr)
    );

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];   // enabled lanes only
        end
        return res;
    endfunction

    function automatic void add_row(op_e op, logic [31:0] addr, logic [31:0] data,
                                    logic [3:0] strb, logic [3:0] delay);
        rows[n_rows] = '{op, addr, data, strb, delay, 32'h0, OKAY};
        n_rows++;
        if (op == OP_WRITE && strb == 4'hf && addr < MEM_BYTES) written_q.push_back(addr);
    endfunction

    function automatic void build_table();
        logic [31:0] a;
        logic [3:0]  dly;
        for (int b = 0; b < NUM_BANKS; b++) begin    // first and last word per bank
            add_row(OP_WRITE, 32'(b*WORDS_PER_BANK*4), $urandom(), 4'hf, 4'd0);
            add_row(OP_WRITE, 32'((b+1)*WORDS_PER_BANK*4 - 4), $urandom(), 4'hf, 4'd0);
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_row(OP_READ, 32'(b*WORDS_PER_BANK*4), 32'h0, 4'h0, 4'd0);
            add_row(OP_READ, 32'((b+1)*WORDS_PER_BANK*4 - 4), 32'h0, 4'h0, 4'd0);
        end
        add_row(OP_WRITE, 32'h0, 32'h1111_11aa, 4'b0001, 4'd0);   // byte merges
        add_row(OP_WRITE, 32'h0, 32'h22bb_cc22, 4'b0110, 4'd0);
        add_row(OP_WRITE, 32'h0, 32'hdd33_3333, 4'b1000, 4'd0);
        add_row(OP_READ,  32'h0, 32'h0, 4'h0, 4'd0);
        add_row(OP_WRITE, 32'h4000, 32'h5566_7788, 4'b1010, 4'd0);
        add_row(OP_READ,  32'h4000, 32'h0, 4'h0, 4'd0);
        add_row(OP_FETCH, 32'h1ffc, 32'h0, 4'h0, 4'd0);           // bank 0 to bank 1
        add_row(OP_FETCH, 32'h2000, 32'h0, 4'h0, 4'd0);
        add_row(OP_FETCH, 32'h7ffc, 32'h0, 4'h0, 4'd0);
        add_row(OP_FETCH, 32'h9ffc, 32'h0, 4'h0, 4'd0);           // wraps to 0x1ffc
        add_row(OP_FETCH, 32'h0001_0000, 32'h0, 4'h0, 4'd0);      // wraps to 0
        add_row(OP_WRITE, 32'h8000, 32'hdead_beef, 4'hf, 4'd0);   // aliases word 0
        add_row(OP_READ,  32'h0, 32'h0, 4'h0, 4'd0);
        add_row(OP_WRITE, 32'hffff_e000, 32'hbad0_bad0, 4'hf, 4'd0);  // aliases 0x6000
        add_row(OP_READ,  32'h6000, 32'h0, 4'h0, 4'd0);
        add_row(OP_READ,  32'h8010, 32'h0, 4'h0, 4'd0);
        add_row(OP_WRITE, 32'h4, $urandom(), 4'hf, 4'($urandom_range(1, 8)));
        add_row(OP_READ,  32'h4, 32'h0, 4'h0, 4'($urandom_range(1, 8)));
        for (int i = 0; i < 24; i++) begin
            a   = written_q[$urandom_range(0, written_q.size() - 1)];
            dly = 4'($urandom_range(0, 6));
            case ($urandom_range(0, 3))
                0: add_row(OP_WRITE, {17'h0, 13'($urandom()), 2'b00}, $urandom(), 4'hf, dly);
                1: add_row(OP_WRITE, a, $urandom(), 4'($urandom()), dly);   // partial
                2: add_row(OP_READ, a, 32'h0, 4'h0, dly);
                default: add_row(OP_FETCH, ($urandom_range(0, 1) == 1) ? a + 32'(MEM_BYTES) : a,
                                 32'h0, 4'h0, 4'd0);
            endcase
        end
    endfunction

    // walk the table in order through the model memory
    function automatic void fill_expected();
        logic [12:0] idx;
        logic        in_range;
        for (int i = 0; i < n_rows; i++) begin
            idx      = 13'((rows[i].addr % MEM_BYTES) / 4);   // fetch wraps at memory size
            in_range = rows[i].addr < MEM_BYTES;
            rows[i].exp_resp = in_range ? OKAY : SLVERR;
            case (rows[i].op)
                OP_WRITE: begin
                    if (in_range) model_mem[idx] = merge_bytes(model_mem[idx], rows[i].data,
                                                                rows[i].strb);
                    rows[i].exp_data = in_range ? model_mem[idx] : 32'h0;  // for parked read
                end
                OP_READ: rows[i].exp_data = in_range ? model_mem[idx] : 32'h0;
                default: begin
                    rows[i].exp_data = model_mem[idx];
                    rows[i].exp_resp = OKAY;
                end
            endcase
        end
    endfunction

    function automatic logic rsp_bit(rsp_sig_e sig);
        case (sig)
            SIG_AW:  return axil_rsp.awready;
            SIG_AR:  return axil_rsp.arready;
            SIG_B:   return axil_rsp.bvalid;
            default: return axil_rsp.rvalid;
        endcase
    endfunction

    // sample 2 ns after the falling edge so the transfer lands on the next rising edge
    task automatic wait_rsp(input rsp_sig_e sig, input string what);
        int n;
        n = 0;
        #2;
        while (rsp_bit(sig) !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (rsp_bit(sig) !== 1'b1) begin
            $display("timeout: the DUT never raised %s within %0d cycles", what, TIMEOUT);
            errors++;
        end
    endtask

    task automatic hold_and_take(input rsp_sig_e sig, input int delay);
        axil_rsp_t snap;
        snap = axil_rsp;                    // response as first seen
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            #2;
            checks++;
            assert (axil_rsp === snap && axil_rsp.arready === 1'b0) else begin
                $display("CHECK FAILED at %0t: %s response moved under back-pressure",
                         $time, sig.name());
                errors++;
            end
        end
        @(negedge clk);
        if (sig == SIG_B) axil_req.bready = 1'b1;
        else axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
        axil_req.rready = 1'b0;
    endtask

    task automatic check_read(input row_t r);
        checks++;
        assert (axil_rsp.rdata === r.exp_data && axil_rsp.rresp === r.exp_resp) else begin
            $display("CHECK FAILED at %0t: read %h gave %h/%s, expected %h/%s", $time, r.addr,
                     axil_rsp.rdata, axil_rsp.rresp.name(), r.exp_data, r.exp_resp.name());
            errors++;
        end
    endtask

    task automatic do_read(input row_t r);
        @(negedge clk);
        axil_req.araddr  = r.addr;
        axil_req.arvalid = 1'b1;
        wait_rsp(SIG_AR, "arready");
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        wait_rsp(SIG_R, "rvalid");
        check_read(r);
        hold_and_take(SIG_R, int'(r.delay));
    endtask

    task automatic do_write(input row_t r);
        @(negedge clk);
        axil_req.awaddr  = r.addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = r.data;
        axil_req.wstrb   = r.strb;
        axil_req.wvalid  = 1'b1;
        if (r.delay != 0) begin
            axil_req.araddr  = r.addr;      // read parked behind the write
            axil_req.arvalid = 1'b1;
        end
        wait_rsp(SIG_AW, "awready");
        checks++;
        assert (axil_rsp.wready === 1'b1 && axil_rsp.arready === 1'b0) else begin
            $display("CHECK FAILED at %0t: wready/arready wrong at write accept", $time);
            errors++;
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        wait_rsp(SIG_B, "bvalid");
        checks++;
        assert (axil_rsp.bresp === r.exp_resp) else begin
            $display("CHECK FAILED at %0t: write %h bresp %s, expected %s", $time, r.addr,
                     axil_rsp.bresp.name(), r.exp_resp.name());
            errors++;
        end
        hold_and_take(SIG_B, int'(r.delay));
        if (r.delay != 0) begin
            wait_rsp(SIG_AR, "arready for the parked read");
            @(negedge clk);
            axil_req.arvalid = 1'b0;
            wait_rsp(SIG_R, "rvalid for the parked read");
            check_read(r);
            hold_and_take(SIG_R, 0);
        end
    endtask

    task automatic do_fetch(input row_t r);
        @(negedge clk);
        pc = r.addr;
        @(negedge clk);                     // sampled on the rising edge between
        checks++;
        assert (instr === r.exp_data) else begin
            $display("CHECK FAILED at %0t: fetch pc %h gave %h, expected %h", $time, r.addr,
                     instr, r.exp_data);
            errors++;
        end
    endtask

    task automatic check_idle_outputs();
        checks++;
        assert (axil_rsp.awready === 1'b0 && axil_rsp.wready === 1'b0 &&
                axil_rsp.arready === 1'b0 && axil_rsp.bvalid === 1'b0 &&
                axil_rsp.rvalid === 1'b0) else begin
            $display("CHECK FAILED at %0t: ready or valid high around reset", $time);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            #2;
            check_idle_outputs();
            n++;
        end while (reset === 1'b1 && n < 4*TIMEOUT);
        if (reset === 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        @(negedge clk);
        #2;
        check_idle_outputs();               // first cycle out of reset
        $display("reset state: %s", (errors == 0) ? "ok" : "FAIL");
    endtask

    initial begin
        int e0;
        axil_req = '0;
        pc       = '0;
        n_rows   = 0;
        errors   = 0;
        checks   = 0;
        void'($urandom(29010));             // one seed for the run
        build_table();
        fill_expected();
        check_reset_state();
        for (int i = 0; i < n_rows; i++) begin
            e0 = errors;
            case (rows[i].op)
                OP_WRITE: do_write(rows[i]);
                OP_READ:  do_read(rows[i]);
                default:  do_fetch(rows[i]);
            endcase
            $display("row %0d %s addr %h: %s", i, rows[i].op.name(), rows[i].addr,
                     (errors == e0) ? "ok" : "FAIL");
        end
        $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
